/* sources.f */
source/cpuMemPkg.sv
source/icache.sv
source/dcache.sv
source/caches.sv
source/memoryControl.sv
source/ram.sv
source/memorySystem.sv
test/memorySystemTb.sv

/* run.sh */
#!/bin/sh
# build and run the memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module memorySystemTb -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported a failure"
  exit 1
fi
exit 0

/* test/memorySystemTb.sv */
//******************************
// memory system testbench
// random traffic on both ports,
// checked against a ram model
//******************************
`default_nettype none

module memorySystemTb;

  localparam int cacheSets     = 16;
  localparam int ramLatency    = 2;
  localparam int ramDepthWords = 1024;
  localparam int instrWords    = 64;
  localparam int dataBase      = ramDepthWords / 2;
  localparam int dataWords     = 32;
  // about 500 requests, each up to twice ramLatency+3 cycles when ports compete
  localparam int timeoutCycles = 20000;

  logic            CLK;
  logic            nRST;
  logic            imemRen;
  cpuMemPkg::wordT imemAddr;
  cpuMemPkg::wordT imemLoad;
  logic            iHit;
  logic            dmemRen;
  logic            dmemWen;
  cpuMemPkg::wordT dmemAddr;
  cpuMemPkg::wordT dmemStore;
  cpuMemPkg::wordT dmemLoad;
  logic            dHit;
  logic            halt;
  logic            flushed;

  // mirror of ram contents
  cpuMemPkg::wordT model [ramDepthWords];
  integer          seed;
  int              cycleCount;
  int              checks;
  int              errors;
  int              testChecks;
  int              testErrors;

  memorySystem #(
    .iCacheSets    (cacheSets),
    .dCacheSets    (cacheSets),
    .ramLatency    (ramLatency),
    .ramDepthWords (ramDepthWords)
  ) memorySystem_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemRen   (imemRen),
    .imemAddr  (imemAddr),
    .imemLoad  (imemLoad),
    .iHit      (iHit),
    .dmemRen   (dmemRen),
    .dmemWen   (dmemWen),
    .dmemAddr  (dmemAddr),
    .dmemStore (dmemStore),
    .dmemLoad  (dmemLoad),
    .dHit      (dHit),
    .halt      (halt),
    .flushed   (flushed)
  );

  initial
  begin
    CLK        = 1'b0;
    cycleCount = 0;
  end

  always #20 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycleCount++;
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout: run stopped after %0d cycles with requests still open", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic cpuMemPkg::wordT randWord();
    randWord = $random(seed);
  endfunction

  function automatic int randBelow(input int n);
    logic [31:0] r;
    r = $random(seed);
    randBelow = int'(r % n);
  endfunction

  task automatic checkWord(input string name, input cpuMemPkg::wordT got,
                           input cpuMemPkg::wordT expected);
    checks++;
    assert (got === expected)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  // called at a falling edge, returns at the falling edge after the hit
  task automatic fetchWord(input int wordIdx, output int waitCycles);
    imemRen    = 1'b1;
    imemAddr   = cpuMemPkg::wordT'(wordIdx) << cpuMemPkg::byteOffsetBits;
    waitCycles = 0;
    #10;
    while (!iHit)
    begin
      @(negedge CLK);
      #10;
      waitCycles++;
    end
    checkWord("imemLoad", imemLoad, model[wordIdx]);
    @(negedge CLK);
    imemRen = 1'b0;
  endtask

  task automatic dataAccess(input bit isStore, input int wordIdx, output int waitCycles);
    cpuMemPkg::wordT value;
    value      = randWord();
    dmemRen    = !isStore;
    dmemWen    = isStore;
    dmemAddr   = cpuMemPkg::wordT'(wordIdx) << cpuMemPkg::byteOffsetBits;
    dmemStore  = value;
    waitCycles = 0;
    #10;
    while (!dHit)
    begin
      @(negedge CLK);
      #10;
      waitCycles++;
    end
    if (isStore)
      model[wordIdx] = value;
    else
      checkWord("dmemLoad", dmemLoad, model[wordIdx]);
    @(negedge CLK);
    dmemRen = 1'b0;
    dmemWen = 1'b0;
  endtask

  task automatic startTest();
    testChecks = checks;
    testErrors = errors;
  endtask

  task automatic endTest(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - testChecks, errors - testErrors);
  endtask

  initial
  begin
    int waitI;
    int waitD;
    int wordA;
    int wordB;
    int k;
    seed      = 32'h9553;
    nRST      = 1'b0;
    imemRen   = 1'b0;
    imemAddr  = '0;
    dmemRen   = 1'b0;
    dmemWen   = 1'b0;
    dmemAddr  = '0;
    dmemStore = '0;
    halt      = 1'b0;
    checks    = 0;
    errors    = 0;
    waitI     = 0;
    waitD     = 0;
    wordA     = 0;
    for (int i = 0; i < ramDepthWords; i++)
      model[i] = '0;

    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    #10;
    checkTrue(!iHit && !dHit && !flushed, "hit or flushed high right after reset");
    @(negedge CLK);

    // instruction region written through the data port first
    startTest();
    for (int i = 0; i < instrWords; i++)
      dataAccess(1'b1, i, waitD);
    for (int i = 0; i < 64; i++)
      fetchWord(randBelow(instrWords), waitI);
    endTest(1, "preload and fetch");

    startTest();
    for (int i = 0; i < 16; i++)
    begin
      wordA = randBelow(instrWords);
      fetchWord(wordA, waitI);
      fetchWord(wordA, waitI);
      checkTrue(waitI == 0, "repeated fetch did not hit in its request cycle");
    end
    endTest(2, "fetch hit timing");

    startTest();
    for (int i = 0; i < 64; i++)
      dataAccess(randBelow(3) == 0, dataBase + randBelow(dataWords), waitD);
    // store into a cached line, then read it back
    for (int i = 0; i < 8; i++)
    begin
      wordB = dataBase + randBelow(dataWords);
      dataAccess(1'b0, wordB, waitD);
      dataAccess(1'b1, wordB, waitD);
      dataAccess(1'b0, wordB, waitD);
      checkTrue(waitD == 0, "load after a store to a cached word missed");
    end
    endTest(3, "store then load");

    startTest();
    k = randBelow(cacheSets);
    for (int i = 0; i < 8; i++)
    begin
      fetchWord(k, waitI);
      checkTrue(i == 0 || waitI > 0, "fetch hit a line that a conflict evicted");
      fetchWord(k + cacheSets, waitI);
      checkTrue(i == 0 || waitI > 0, "fetch hit a line that a conflict evicted");
      dataAccess(1'b0, dataBase + k, waitD);
      checkTrue(i == 0 || waitD > 0, "load hit a line that a conflict evicted");
      dataAccess(1'b0, dataBase + k + cacheSets, waitD);
      checkTrue(i == 0 || waitD > 0, "load hit a line that a conflict evicted");
    end
    endTest(4, "conflict eviction");

    startTest();
    for (int i = 0; i < 100; i++)
    begin
      wordA = randBelow(instrWords);
      wordB = dataBase + randBelow(dataWords);
      k     = randBelow(2);
      fork
        fetchWord(wordA, waitI);
        dataAccess(k == 1, wordB, waitD);
      join
    end
    endTest(5, "concurrent traffic");

    startTest();
    wordB = dataBase + randBelow(dataWords);
    dataAccess(1'b0, wordB, waitD);
    dataAccess(1'b1, wordB, waitD);
    #10;
    checkTrue(!flushed, "flushed high before halt");
    @(negedge CLK);
    halt = 1'b1;
    #10;
    checkTrue(!flushed, "flushed high in the first halt cycle");
    for (int i = 0; i < 4; i++)
    begin
      @(negedge CLK);
      #10;
      checkTrue(flushed, "flushed low while halt was held");
    end
    @(negedge CLK);
    halt = 1'b0;
    #10;
    checkTrue(!flushed, "flushed still high after halt was released");
    @(negedge CLK);
    // both caches were cleared, so these go to memory
    dataAccess(1'b0, wordB, waitD);
    checkTrue(waitD > 0, "load after halt hit an invalidated line");
    fetchWord(wordA, waitI);
    checkTrue(waitI > 0, "fetch after halt hit an invalidated line");
    endTest(6, "halt");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/memorySystem.sv */
//******************************
// memory system
// caches, memory controller and ram
//******************************
`default_nettype none

module memorySystem #(
  parameter int iCacheSets    = 16,
  parameter int dCacheSets    = 16,
  parameter int ramLatency    = 2,
  parameter int ramDepthWords = 1024
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            imemRen,
  input  cpuMemPkg::wordT imemAddr,
  output cpuMemPkg::wordT imemLoad,
  output logic            iHit,
  input  logic            dmemRen,
  input  logic            dmemWen,
  input  cpuMemPkg::wordT dmemAddr,
  input  cpuMemPkg::wordT dmemStore,
  output cpuMemPkg::wordT dmemLoad,
  output logic            dHit,
  input  logic            halt,
  output logic            flushed
);

  // cache side of the controller
  logic            iRen, iWait, dRen, dWen, dWait;
  cpuMemPkg::wordT iAddr, iLoad, dAddr, dStore, dLoad;

  // ram port
  cpuMemPkg::memOpT    ramOp;
  cpuMemPkg::ramStateT ramState;
  cpuMemPkg::wordT     ramAddr, ramStore, ramLoad;

  caches #(.iCacheSets(iCacheSets), .dCacheSets(dCacheSets)) caches_i (
    .CLK(CLK), .nRST(nRST),
    .imemRen(imemRen), .imemAddr(imemAddr), .imemLoad(imemLoad), .iHit(iHit),
    .dmemRen(dmemRen), .dmemWen(dmemWen), .dmemAddr(dmemAddr),
    .dmemStore(dmemStore), .dmemLoad(dmemLoad), .dHit(dHit),
    .halt(halt), .flushed(flushed),
    .iRen(iRen), .iAddr(iAddr), .dRen(dRen), .dWen(dWen),
    .dAddr(dAddr), .dStore(dStore),
    .iLoad(iLoad), .iWait(iWait), .dLoad(dLoad), .dWait(dWait)
  );

  memoryControl memoryControl_i (
    .CLK(CLK), .nRST(nRST),
    .iRen(iRen), .iAddr(iAddr), .dRen(dRen), .dWen(dWen),
    .dAddr(dAddr), .dStore(dStore),
    .iLoad(iLoad), .iWait(iWait), .dLoad(dLoad), .dWait(dWait),
    .ramOp(ramOp), .ramAddr(ramAddr), .ramStore(ramStore),
    .ramLoad(ramLoad), .ramState(ramState)
  );

  ram #(.ramLatency(ramLatency), .ramDepthWords(ramDepthWords)) ram_i (
    .CLK(CLK), .nRST(nRST),
    .ramOp(ramOp), .ramAddr(ramAddr), .ramStore(ramStore),
    .ramLoad(ramLoad), .ramState(ramState)
  );

endmodule

`default_nettype wire

/* source/ram.sv */
//******************************
// ram
// word memory with a fixed
// access latency
//******************************
`default_nettype none

module ram #(
  parameter int ramLatency    = 2,
  parameter int ramDepthWords = 1024
) (
  input  logic                CLK,
  input  logic                nRST,
  input  cpuMemPkg::memOpT    ramOp,
  input  cpuMemPkg::wordT     ramAddr,
  input  cpuMemPkg::wordT     ramStore,
  output cpuMemPkg::wordT     ramLoad,
  output cpuMemPkg::ramStateT ramState
);

  localparam int idxBits = $clog2(ramDepthWords);
  localparam int cntBits = $clog2(ramLatency + 1);

  cpuMemPkg::wordT  mem [ramDepthWords];
  cpuMemPkg::memOpT prevOp;
  cpuMemPkg::wordT  prevAddr;
  logic [cntBits-1:0] cnt;
  logic [cntBits-1:0] elapsed;
  logic [idxBits-1:0] wordIdx;
  logic               same;

  initial
  begin
    for (int i = 0; i < ramDepthWords; i++)
      mem[i] = '0;
  end

  assign wordIdx = ramAddr[cpuMemPkg::byteOffsetBits +: idxBits];

  // a new op or address starts the count again
  assign same    = (ramOp == prevOp) && (ramAddr == prevAddr);
  assign elapsed = same ? cnt : '0;

  always_comb
  begin
    if (ramOp == cpuMemPkg::MEM_IDLE)
      ramState = cpuMemPkg::FREE;
    else if (elapsed == cntBits'(ramLatency))
      ramState = cpuMemPkg::ACCESS;
    else
      ramState = cpuMemPkg::BUSY;
  end

  assign ramLoad = mem[wordIdx];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      prevOp   <= cpuMemPkg::MEM_IDLE;
      prevAddr <= '0;
      cnt      <= '0;
    end
    else
    begin
      prevOp   <= ramOp;
      prevAddr <= ramAddr;
      if (ramState == cpuMemPkg::BUSY)
        cnt <= elapsed + 1'b1;
      else
        cnt <= '0;
    end
  end

  // store lands at the end of its access cycle
  always_ff @(posedge CLK)
  begin
    if ((ramState == cpuMemPkg::ACCESS) && (ramOp == cpuMemPkg::MEM_DSTORE))
      mem[wordIdx] <= ramStore;
  end

endmodule

`default_nettype wire

/* source/memoryControl.sv */
//******************************
// memory controller
// puts both cache ports on one ram
// port, data side first
//******************************
`default_nettype none

module memoryControl (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                iRen,
  input  cpuMemPkg::wordT     iAddr,
  input  logic                dRen,
  input  logic                dWen,
  input  cpuMemPkg::wordT     dAddr,
  input  cpuMemPkg::wordT     dStore,
  output cpuMemPkg::wordT     iLoad,
  output logic                iWait,
  output cpuMemPkg::wordT     dLoad,
  output logic                dWait,
  output cpuMemPkg::memOpT    ramOp,
  output cpuMemPkg::wordT     ramAddr,
  output cpuMemPkg::wordT     ramStore,
  input  cpuMemPkg::wordT     ramLoad,
  input  cpuMemPkg::ramStateT ramState
);

  logic dReq;
  logic serveData;
  logic serveInstr;
  logic locked;
  logic lockData;
  logic ramDone;

  assign dReq    = dRen || dWen;
  assign ramDone = (ramState == cpuMemPkg::ACCESS);

  // once started, an access keeps its port until ram finishes
  assign serveData  = dReq && (!locked || lockData);
  assign serveInstr = iRen && (locked ? !lockData : !dReq);

  always_comb
  begin
    ramOp = cpuMemPkg::MEM_IDLE;
    if (serveData)
      ramOp = dWen ? cpuMemPkg::MEM_DSTORE : cpuMemPkg::MEM_DLOAD;
    else if (serveInstr)
      ramOp = cpuMemPkg::MEM_IFETCH;
  end

  assign ramAddr  = serveData ? dAddr : iAddr;
  assign ramStore = dStore;

  // port not being served sees wait high
  assign dWait = !(serveData && ramDone);
  assign iWait = !(serveInstr && ramDone);
  assign dLoad = ramLoad;
  assign iLoad = ramLoad;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      locked   <= 1'b0;
      lockData <= 1'b0;
    end
    else if (ramDone)
      locked <= 1'b0;
    else if (serveData || serveInstr)
    begin
      locked   <= 1'b1;
      lockData <= serveData;
    end
  end

  // caches hold their address until the access ends
  assert property (@(posedge CLK) disable iff (!nRST)
    (ramOp != cpuMemPkg::MEM_IDLE) && !ramDone |=> $stable(ramAddr));

endmodule

`default_nettype wire

/* source/caches.sv */
//******************************
// caches
// instruction and data cache pair,
// fetch hold and halt flush
//******************************
`default_nettype none

module caches #(
  parameter int iCacheSets = 16,
  parameter int dCacheSets = 16
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            imemRen,
  input  cpuMemPkg::wordT imemAddr,
  output cpuMemPkg::wordT imemLoad,
  output logic            iHit,
  input  logic            dmemRen,
  input  logic            dmemWen,
  input  cpuMemPkg::wordT dmemAddr,
  input  cpuMemPkg::wordT dmemStore,
  output cpuMemPkg::wordT dmemLoad,
  output logic            dHit,
  input  logic            halt,
  output logic            flushed,
  output logic            iRen,
  output cpuMemPkg::wordT iAddr,
  output logic            dRen,
  output logic            dWen,
  output cpuMemPkg::wordT dAddr,
  output cpuMemPkg::wordT dStore,
  input  cpuMemPkg::wordT iLoad,
  input  logic            iWait,
  input  cpuMemPkg::wordT dLoad,
  input  logic            dWait
);

  cpuMemPkg::wordT icLoad;
  cpuMemPkg::wordT lastInstr;
  logic            dBusy;
  logic            invalidate;
  logic            flushDone;

  icache #(.iCacheSets(iCacheSets)) icache_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .imemRen    (imemRen),
    .imemAddr   (imemAddr),
    .invalidate (invalidate),
    .imemLoad   (icLoad),
    .iHit       (iHit),
    .iRen       (iRen),
    .iAddr      (iAddr),
    .iLoad      (iLoad),
    .iWait      (iWait)
  );

  dcache #(.dCacheSets(dCacheSets)) dcache_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmemRen    (dmemRen),
    .dmemWen    (dmemWen),
    .dmemAddr   (dmemAddr),
    .dmemStore  (dmemStore),
    .invalidate (invalidate),
    .dmemLoad   (dmemLoad),
    .dHit       (dHit),
    .busy       (dBusy),
    .dRen       (dRen),
    .dWen       (dWen),
    .dAddr      (dAddr),
    .dStore     (dStore),
    .dLoad      (dLoad),
    .dWait      (dWait)
  );

  // stalled pipeline re-reads the last fetched word
  assign imemLoad = iHit ? icLoad : lastInstr;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      lastInstr <= '0;
    else if (iHit)
      lastInstr <= icLoad;
  end

  // clear both caches once the data side is quiet
  assign invalidate = halt && !dBusy;
  assign flushed    = halt && flushDone;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      flushDone <= 1'b0;
    else
      flushDone <= halt && !dBusy;
  end

  // no data traffic once the flush is done
  assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !dBusy);

endmodule

`default_nettype wire

/* source/dcache.sv */
//******************************
// data cache
// direct mapped, write through,
// no allocate on a store miss
//******************************
`default_nettype none

module dcache #(
  parameter int dCacheSets = 16
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            dmemRen,
  input  logic            dmemWen,
  input  cpuMemPkg::wordT dmemAddr,
  input  cpuMemPkg::wordT dmemStore,
  input  logic            invalidate,
  output cpuMemPkg::wordT dmemLoad,
  output logic            dHit,
  output logic            busy,
  output logic            dRen,
  output logic            dWen,
  output cpuMemPkg::wordT dAddr,
  output cpuMemPkg::wordT dStore,
  input  cpuMemPkg::wordT dLoad,
  input  logic            dWait
);

  localparam int idxBits = $clog2(dCacheSets);
  localparam int tagBits = 32 - idxBits - cpuMemPkg::byteOffsetBits;

  cpuMemPkg::cacheStateT state;
  logic [dCacheSets-1:0] valid;
  logic [tagBits-1:0]    tags [dCacheSets];
  cpuMemPkg::wordT       lines [dCacheSets];

  logic [idxBits-1:0] idx;
  logic [tagBits-1:0] tag;
  logic               tagHit;
  logic               fillNow;
  logic               storeDone;

  assign idx    = dmemAddr[cpuMemPkg::byteOffsetBits +: idxBits];
  assign tag    = dmemAddr[31 -: tagBits];
  assign tagHit = valid[idx] && (tags[idx] == tag);

  // loads go out only on a miss, stores always
  assign dRen   = (state == cpuMemPkg::MISS) || (dmemRen && !tagHit);
  assign dWen   = dmemWen;
  assign dAddr  = dmemAddr;
  assign dStore = dmemStore;
  assign busy   = dRen || dWen;

  assign fillNow   = dRen && !dWait;
  assign storeDone = dWen && !dWait;

  assign dHit     = (dmemRen && tagHit) || fillNow || storeDone;
  assign dmemLoad = fillNow ? dLoad : lines[idx];

  // MISS only tracks loads; a store is held by the datapath itself
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      state <= cpuMemPkg::IDLE;
    else if (dRen && dWait)
      state <= cpuMemPkg::MISS;
    else
      state <= cpuMemPkg::IDLE;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      valid <= '0;
    else if (invalidate)
      valid <= '0;
    else if (fillNow)
      valid[idx] <= 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (fillNow)
    begin
      tags[idx]  <= tag;
      lines[idx] <= dLoad;
    end
    else if (storeDone && tagHit)
      // keep a cached copy in step with memory
      lines[idx] <= dmemStore;
  end

  // one kind of memory access at a time
  assert property (@(posedge CLK) disable iff (!nRST) !(dRen && dWen));

endmodule

`default_nettype wire

/* source/icache.sv */
//******************************
// instruction cache
// direct mapped, read only, one word
// per line, fills on a miss
//******************************
`default_nettype none

module icache #(
  parameter int iCacheSets = 16
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            imemRen,
  input  cpuMemPkg::wordT imemAddr,
  input  logic            invalidate,
  output cpuMemPkg::wordT imemLoad,
  output logic            iHit,
  output logic            iRen,
  output cpuMemPkg::wordT iAddr,
  input  cpuMemPkg::wordT iLoad,
  input  logic            iWait
);

  localparam int idxBits = $clog2(iCacheSets);
  localparam int tagBits = 32 - idxBits - cpuMemPkg::byteOffsetBits;

  cpuMemPkg::cacheStateT state;
  logic [iCacheSets-1:0] valid;
  logic [tagBits-1:0]    tags [iCacheSets];
  cpuMemPkg::wordT       lines [iCacheSets];

  logic [idxBits-1:0] idx;
  logic [tagBits-1:0] tag;
  logic               tagHit;
  logic               fillNow;

  assign idx    = imemAddr[cpuMemPkg::byteOffsetBits +: idxBits];
  assign tag    = imemAddr[31 -: tagBits];
  assign tagHit = valid[idx] && (tags[idx] == tag);

  // request goes out in the first miss cycle and is held after that
  assign iRen    = (state == cpuMemPkg::MISS) || (imemRen && !tagHit);
  assign iAddr   = imemAddr;
  assign fillNow = iRen && !iWait;

  // a fill answers the fetch in the same cycle
  assign iHit     = (imemRen && tagHit) || fillNow;
  assign imemLoad = fillNow ? iLoad : lines[idx];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      state <= cpuMemPkg::IDLE;
    else if (iRen && iWait)
      state <= cpuMemPkg::MISS;
    else
      state <= cpuMemPkg::IDLE;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      valid <= '0;
    else if (invalidate)
      valid <= '0;
    else if (fillNow)
      valid[idx] <= 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (fillNow)
    begin
      tags[idx]  <= tag;
      lines[idx] <= iLoad;
    end
  end

  // miss request and its address must hold until memory answers
  assert property (@(posedge CLK) disable iff (!nRST)
    iRen && iWait |=> iRen && $stable(iAddr));

endmodule

`default_nettype wire

/* source/cpuMemPkg.sv */
//******************************
// cpu memory package
// word type, address split and the
// enums used on the memory side
//******************************
`default_nettype none

package cpuMemPkg;

  // one data or address word
  typedef logic [31:0] wordT;

  // byte address bits below the word index
  localparam int byteOffsetBits = 2;

  // cache controller: serving hits or waiting on memory
  typedef enum logic
  {
    IDLE,
    MISS
  } cacheStateT;

  // operation presented to the ram
  typedef enum logic [1:0]
  {
    MEM_IDLE,
    MEM_IFETCH,
    MEM_DLOAD,
    MEM_DSTORE
  } memOpT;

  // ram progress through one access
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS
  } ramStateT;

endpackage

`default_nettype wire
